//--- common/ifm_pkg.sv
// ingress frame manager shared definitions
// beat and fifo sizing, almost-full margin, stored beat and status formats
package ifm_pkg;

   // mac beat, 64 data bits with one keep bit per byte
   localparam int DATA_W = 64;
   localparam int KEEP_W = 8;

   // data fifo holds beats, info fifo holds one word per stored frame
   localparam int DATA_DEPTH = 32;
   localparam int INFO_DEPTH = 8;

   // free entries at or below which a new frame is refused
   // a started frame of up to 10 beats always fits
   localparam int AFULL_MARGIN = 10;

   // occupancy where the data fifo starts to report almost full
   localparam int DATA_AFULL_LEVEL = DATA_DEPTH - AFULL_MARGIN;

   // drop counters
   localparam int CNT_W = 16;

   // beat count field of the status word
   localparam int BCNT_W = 7;

   // one beat as held in the data fifo, 73 bits
   typedef struct packed {
      // end of frame marker
      logic              last;
      // byte enables
      logic [KEEP_W-1:0] keep;
      logic [DATA_W-1:0] data;
   } data_beat_t;

   // one status word per stored frame, 8 bits
   typedef struct packed {
      // number of beats in the frame
      logic [BCNT_W-1:0] beats;
      // mac good flag from the last beat
      logic              good;
   } frame_info_t;

endpackage

//--- verilog/ifm_fifo.sv
`timescale 1ns/1ps
// synchronous fifo with show-ahead read
// generic payload type, occupancy based almost-full and empty flags
module ifm_fifo #(
   parameter type payload_t   = logic [7:0],
   parameter int  DEPTH       = 8,
   parameter int  AFULL_LEVEL = DEPTH
) (
   input  logic     rx_clk,
   input  logic     rx_reset,
   input  logic     wren,
   input  payload_t wdata,
   input  logic     rden,
   output payload_t rdata,
   output logic     empty,
   output logic     afull
);

   payload_t                     mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]     wr_ptr;
   logic [$clog2(DEPTH)-1:0]     rd_ptr;
   // occupancy, one bit wider than the pointers
   logic [$clog2(DEPTH+1)-1:0]   count;
   logic                         full;

   // flags straight from the occupancy
   assign empty = (count == 0);
   assign full  = (count == DEPTH);
   assign afull = (count >= AFULL_LEVEL);

   // head word is always presented
   assign rdata = mem[rd_ptr];

   // storage
   always_ff @(posedge rx_clk)
   begin
      if (wren)
         mem[wr_ptr] <= wdata;
   end

   // pointers and occupancy
   always_ff @(posedge rx_clk or posedge rx_reset)
   begin
      if (rx_reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // wrap at depth, works for non power of two too
         if (wren)
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         if (rden)
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         case ({wren, rden})
            2'b10:
               count <= count + 1'b1;
            2'b01:
               count <= count - 1'b1;
            default:
               count <= count;
         endcase
      end
   end

   // writer must respect the depth
   a_no_overflow: assert property (@(posedge rx_clk) disable iff (rx_reset)
      wren |-> !full);

   // reader only pops a present word
   a_no_underflow: assert property (@(posedge rx_clk) disable iff (rx_reset)
      rden |-> !empty);

endmodule

//--- ifm_in/ifm_in_fsm.sv
`timescale 1ns/1ps
// ingress receive state machine
// stores or drops each mac frame whole and writes the data and info fifos
module ifm_in_fsm
   import ifm_pkg::*;
(
   input  logic              rx_clk,
   input  logic              rx_reset,
   input  logic              rx_axis_mac_tvalid,
   input  logic [DATA_W-1:0] rx_axis_mac_tdata,
   input  logic [KEEP_W-1:0] rx_axis_mac_tkeep,
   input  logic              rx_axis_mac_tlast,
   input  logic              rx_axis_mac_tuser,
   input  logic              data_afull,
   output logic              data_wren,
   output data_beat_t        data_wdata,
   output logic              info_wren,
   output frame_info_t       info_wdata,
   output logic [CNT_W-1:0]  drop_full_count
);

   typedef enum logic [1:0] {ST_IDLE, ST_PASS, ST_DROP} state_t;

   state_t            state;
   state_t            state_nxt;
   logic              first_beat;
   logic              drop_start;
   logic              store_beat;
   logic [BCNT_W-1:0] beat_cnt;
   logic [BCNT_W-1:0] frame_beats;

   // any beat seen in idle opens a frame
   assign first_beat = rx_axis_mac_tvalid && (state == ST_IDLE);
   // no room, refuse the whole frame
   assign drop_start = first_beat && data_afull;
   // beats that go to the data fifo
   assign store_beat = (first_beat && !data_afull) ||
                       (rx_axis_mac_tvalid && (state == ST_PASS));
   // beat count including the current beat
   assign frame_beats = (state == ST_IDLE) ? BCNT_W'(1) : beat_cnt + 1'b1;

   // next state, single beat frames never leave idle
   always_comb
   begin
      state_nxt = state;
      case (state)
         ST_IDLE:
         begin
            if (rx_axis_mac_tvalid && !rx_axis_mac_tlast)
               state_nxt = data_afull ? ST_DROP : ST_PASS;
         end
         ST_PASS, ST_DROP:
         begin
            if (rx_axis_mac_tvalid && rx_axis_mac_tlast)
               state_nxt = ST_IDLE;
         end
         default:
            state_nxt = ST_IDLE;
      endcase
   end

   // control state and write strobes
   always_ff @(posedge rx_clk or posedge rx_reset)
   begin
      if (rx_reset)
      begin
         state           <= ST_IDLE;
         data_wren       <= 1'b0;
         info_wren       <= 1'b0;
         beat_cnt        <= '0;
         drop_full_count <= '0;
      end
      else
      begin
         state     <= state_nxt;
         data_wren <= store_beat;
         // status goes out with the last stored beat, one beat frames too
         info_wren <= store_beat && rx_axis_mac_tlast;
         if (store_beat)
            beat_cnt <= frame_beats;
         // one count per refused frame
         if (drop_start)
            drop_full_count <= drop_full_count + 1'b1;
      end
   end

   // payload registers, qualified by the write strobes
   always_ff @(posedge rx_clk)
   begin
      data_wdata.data <= rx_axis_mac_tdata;
      data_wdata.keep <= rx_axis_mac_tkeep;
      data_wdata.last <= rx_axis_mac_tlast;
      if (store_beat && rx_axis_mac_tlast)
      begin
         info_wdata.good  <= rx_axis_mac_tuser;
         info_wdata.beats <= frame_beats;
      end
   end

   // a frame refused at its first beat writes nothing up to and including
   // the write slot of its own last beat
   a_drop_no_write: assert property (@(posedge rx_clk) disable iff (rx_reset)
      drop_start |=> (!data_wren && !info_wren) until_with
         $past(rx_axis_mac_tvalid && rx_axis_mac_tlast));

endmodule

//--- ifm_out/ifm_out_fsm.sv
`timescale 1ns/1ps
// egress side of the frame manager
// pops one status word per frame, forwards good frames and discards bad ones
module ifm_out_fsm
   import ifm_pkg::*;
(
   input  logic              rx_clk,
   input  logic              rx_reset,
   input  logic              out_hold,
   input  frame_info_t       info_rdata,
   input  logic              info_empty,
   input  data_beat_t        data_rdata,
   input  logic              data_empty,
   output logic              info_rden,
   output logic              data_rden,
   output logic              out_valid,
   output logic [DATA_W-1:0] out_data,
   output logic [KEEP_W-1:0] out_keep,
   output logic              out_last,
   output logic [CNT_W-1:0]  drop_bad_count
);

   typedef enum logic [1:0] {ST_IDLE, ST_FORWARD, ST_DISCARD} state_t;

   state_t state;
   logic   frame_end;

   // pop the next status word, only when not held
   assign info_rden = (state == ST_IDLE) && !info_empty && !out_hold;

   // one beat per cycle while a frame is open and not held
   // all beats of a frame are in the data fifo before its status word
   assign data_rden = (state != ST_IDLE) && !out_hold;

   // last beat of the current frame leaves the fifo
   assign frame_end = data_rden && data_rdata.last;

   // frame sequencing and bad frame counter
   always_ff @(posedge rx_clk or posedge rx_reset)
   begin
      if (rx_reset)
      begin
         state          <= ST_IDLE;
         out_valid      <= 1'b0;
         drop_bad_count <= '0;
      end
      else
      begin
         out_valid <= (state == ST_FORWARD) && data_rden;
         case (state)
            ST_IDLE:
            begin
               // good flag picks the path for the whole frame
               if (info_rden)
                  state <= info_rdata.good ? ST_FORWARD : ST_DISCARD;
            end
            ST_FORWARD:
            begin
               if (frame_end)
                  state <= ST_IDLE;
            end
            ST_DISCARD:
            begin
               // counted once, at the frame's last beat
               if (frame_end)
               begin
                  state          <= ST_IDLE;
                  drop_bad_count <= drop_bad_count + 1'b1;
               end
            end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   // output beat registers, qualified by out_valid
   always_ff @(posedge rx_clk)
   begin
      if (data_rden)
      begin
         out_data <= data_rdata.data;
         out_keep <= data_rdata.keep;
         out_last <= data_rdata.last;
      end
   end

   // in side writes the status word with the last beat, so an open
   // frame always has beats waiting
   a_frame_data_present: assert property (@(posedge rx_clk) disable iff (rx_reset)
      (state != ST_IDLE) |-> !data_empty);

endmodule

//--- verilog/ifm_top.sv
`timescale 1ns/1ps
// ingress frame manager receive subsystem
// in state machine, data and info fifos, out state machine
module ifm_top
   import ifm_pkg::*;
(
   input  logic              rx_clk,
   input  logic              rx_reset,
   input  logic              rx_axis_mac_tvalid,
   input  logic [DATA_W-1:0] rx_axis_mac_tdata,
   input  logic [KEEP_W-1:0] rx_axis_mac_tkeep,
   input  logic              rx_axis_mac_tlast,
   input  logic              rx_axis_mac_tuser,
   input  logic              out_hold,
   output logic              out_valid,
   output logic [DATA_W-1:0] out_data,
   output logic [KEEP_W-1:0] out_keep,
   output logic              out_last,
   output logic [CNT_W-1:0]  drop_full_count,
   output logic [CNT_W-1:0]  drop_bad_count
);

   // data fifo side
   logic        data_wren;
   data_beat_t  data_wdata;
   logic        data_afull;
   logic        data_rden;
   data_beat_t  data_rdata;
   logic        data_empty;

   // info fifo side
   logic        info_wren;
   frame_info_t info_wdata;
   logic        info_rden;
   frame_info_t info_rdata;
   logic        info_empty;

   // accept or drop at first beat
   ifm_in_fsm in_fsm0 (
      .rx_clk             (rx_clk),
      .rx_reset           (rx_reset),
      .rx_axis_mac_tvalid (rx_axis_mac_tvalid),
      .rx_axis_mac_tdata  (rx_axis_mac_tdata),
      .rx_axis_mac_tkeep  (rx_axis_mac_tkeep),
      .rx_axis_mac_tlast  (rx_axis_mac_tlast),
      .rx_axis_mac_tuser  (rx_axis_mac_tuser),
      .data_afull         (data_afull),
      .data_wren          (data_wren),
      .data_wdata         (data_wdata),
      .info_wren          (info_wren),
      .info_wdata         (info_wdata),
      .drop_full_count    (drop_full_count)
   );

   // frame beats
   ifm_fifo #(
      .payload_t   (data_beat_t),
      .DEPTH       (DATA_DEPTH),
      .AFULL_LEVEL (DATA_AFULL_LEVEL)
   ) data_fifo0 (
      .rx_clk   (rx_clk),
      .rx_reset (rx_reset),
      .wren     (data_wren),
      .wdata    (data_wdata),
      .rden     (data_rden),
      .rdata    (data_rdata),
      .empty    (data_empty),
      .afull    (data_afull)
   );

   // status words, afull not needed here
   ifm_fifo #(
      .payload_t   (frame_info_t),
      .DEPTH       (INFO_DEPTH),
      .AFULL_LEVEL (INFO_DEPTH)
   ) info_fifo0 (
      .rx_clk   (rx_clk),
      .rx_reset (rx_reset),
      .wren     (info_wren),
      .wdata    (info_wdata),
      .rden     (info_rden),
      .rdata    (info_rdata),
      .empty    (info_empty),
      .afull    ()
   );

   // forward or discard per status word
   ifm_out_fsm out_fsm0 (
      .rx_clk         (rx_clk),
      .rx_reset       (rx_reset),
      .out_hold       (out_hold),
      .info_rdata     (info_rdata),
      .info_empty     (info_empty),
      .data_rdata     (data_rdata),
      .data_empty     (data_empty),
      .info_rden      (info_rden),
      .data_rden      (data_rden),
      .out_valid      (out_valid),
      .out_data       (out_data),
      .out_keep       (out_keep),
      .out_last       (out_last),
      .drop_bad_count (drop_bad_count)
   );

endmodule

//--- test/ifm_tb.sv
`timescale 1ns/1ps
// ingress frame manager testbench
// replays frames from the stim file, checks forwarded beats and drop counters
module ifm_tb
   import ifm_pkg::*;
;

   localparam string STIM_PATH = "test/ifm_stim.txt";
   // drain wait per test, longest drain is one full hold window
   localparam int    DRAIN_MAX = 64;
   localparam int    BEAT_W    = DATA_W + KEEP_W + 1;

   logic              rx_clk;
   logic              rx_reset;
   logic              rx_axis_mac_tvalid;
   logic [DATA_W-1:0] rx_axis_mac_tdata;
   logic [KEEP_W-1:0] rx_axis_mac_tkeep;
   logic              rx_axis_mac_tlast;
   logic              rx_axis_mac_tuser;
   logic              out_hold;
   logic              out_valid;
   logic [DATA_W-1:0] out_data;
   logic [KEEP_W-1:0] out_keep;
   logic              out_last;
   logic [CNT_W-1:0]  drop_full_count;
   logic [CNT_W-1:0]  drop_bad_count;

   // beats kept as {last, keep, data}
   logic [BEAT_W-1:0] got_q[$];
   logic [BEAT_W-1:0] exp_q[$];
   string             lines[$];
   string             test_name;
   int                exp_full;
   int                exp_bad;
   int                pass_cnt;
   int                fail_cnt;
   int                cycle_cnt;
   int                cycle_limit;

   ifm_top dut0 (
      .rx_clk             (rx_clk),
      .rx_reset           (rx_reset),
      .rx_axis_mac_tvalid (rx_axis_mac_tvalid),
      .rx_axis_mac_tdata  (rx_axis_mac_tdata),
      .rx_axis_mac_tkeep  (rx_axis_mac_tkeep),
      .rx_axis_mac_tlast  (rx_axis_mac_tlast),
      .rx_axis_mac_tuser  (rx_axis_mac_tuser),
      .out_hold           (out_hold),
      .out_valid          (out_valid),
      .out_data           (out_data),
      .out_keep           (out_keep),
      .out_last           (out_last),
      .drop_full_count    (drop_full_count),
      .drop_bad_count     (drop_bad_count)
   );

   // 8 ns period
   always #4 rx_clk = ~rx_clk;

   // forwarded beats, registered outputs read before the edge updates them
   always @(posedge rx_clk)
   begin
      if (out_valid)
         got_q.push_back({out_last, out_keep, out_data});
   end

   // run limit from the stim length
   always @(posedge rx_clk)
   begin
      cycle_cnt++;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   // beat i of an n beat frame, data counts up from d0, keep narrows on last
   function automatic logic [BEAT_W-1:0] frame_beat(input int n, input int i,
                                                    input logic [DATA_W-1:0] d0,
                                                    input logic [KEEP_W-1:0] kl);
      logic l;
      l = (i == n - 1);
      return {l, l ? kl : {KEEP_W{1'b1}}, d0 + DATA_W'(i)};
   endfunction

   // one mac cycle, driven on the falling edge
   task automatic drive_beat(input logic v, input logic [DATA_W-1:0] d,
                             input logic [KEEP_W-1:0] k, input logic l, input logic u);
      @(negedge rx_clk);
      rx_axis_mac_tvalid = v;
      rx_axis_mac_tdata  = d;
      rx_axis_mac_tkeep  = k;
      rx_axis_mac_tlast  = l;
      rx_axis_mac_tuser  = u;
   endtask

   task automatic send_frame(input int n, input logic [DATA_W-1:0] d0,
                             input logic [KEEP_W-1:0] kl, input logic u);
      logic [BEAT_W-1:0] b;
      for (int i = 0; i < n; i++)
      begin
         b = frame_beat(n, i, d0, kl);
         drive_beat(1'b1, b[DATA_W-1:0], b[BEAT_W-2:DATA_W], b[BEAT_W-1], u);
      end
   endtask

   // mid-stream reset, mac goes quiet meanwhile
   task automatic pulse_reset();
      @(negedge rx_clk);
      rx_reset           = 1'b1;
      rx_axis_mac_tvalid = 1'b0;
      repeat (3) @(negedge rx_clk);
      rx_reset = 1'b0;
   endtask

   // drain the open test, then compare beats and counters
   task automatic close_test();
      int waited;
      int errors;
      waited = 0;
      errors = 0;
      if (test_name != "")
      begin
         drive_beat(1'b0, '0, '0, 1'b0, 1'b0);
         while (waited < DRAIN_MAX && !(got_q.size() >= exp_q.size() &&
                drop_full_count == exp_full && drop_bad_count == exp_bad))
         begin
            @(negedge rx_clk);
            waited++;
         end
         // room for surplus beats to show up
         repeat (4) @(negedge rx_clk);
         assert (got_q.size() == exp_q.size())
         else
         begin
            $display("CHECK FAILED t=%0t %s: %0d beats out, expected %0d",
                     $time, test_name, got_q.size(), exp_q.size());
            errors++;
         end
         for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
         begin
            assert (got_q[i] === exp_q[i])
            else
            begin
               $display("CHECK FAILED t=%0t %s: beat %0d is %h, expected %h",
                        $time, test_name, i, got_q[i], exp_q[i]);
               errors++;
            end
         end
         assert (drop_full_count === CNT_W'(exp_full))
         else
         begin
            $display("CHECK FAILED t=%0t %s: drop_full_count %0d, expected %0d",
                     $time, test_name, drop_full_count, exp_full);
            errors++;
         end
         assert (drop_bad_count === CNT_W'(exp_bad))
         else
         begin
            $display("CHECK FAILED t=%0t %s: drop_bad_count %0d, expected %0d",
                     $time, test_name, drop_bad_count, exp_bad);
            errors++;
         end
         if (errors == 0)
         begin
            pass_cnt++;
            $display("test %s: ok", test_name);
         end
         else
         begin
            fail_cnt++;
            $display("test %s: %0d errors", test_name, errors);
         end
      end
   endtask

   initial
   begin
      int                fd;
      int                n;
      int                v;
      int                l;
      int                u;
      string             line;
      string             tag;
      string             name;
      logic [DATA_W-1:0] d;
      logic [KEEP_W-1:0] k;
      rx_clk             = 1'b0;
      rx_reset           = 1'b1;
      rx_axis_mac_tvalid = 1'b0;
      rx_axis_mac_tdata  = '0;
      rx_axis_mac_tkeep  = '0;
      rx_axis_mac_tlast  = 1'b0;
      rx_axis_mac_tuser  = 1'b0;
      out_hold           = 1'b0;
      test_name          = "";
      fd = $fopen(STIM_PATH, "r");
      if (fd == 0)
      begin
         $display("cannot open stimulus file %s", STIM_PATH);
         fail_cnt++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            if ($fgets(line, fd) > 0)
               lines.push_back(line);
         end
         $fclose(fd);
      end
      cycle_limit = 4 * lines.size() + 200;
      repeat (10) @(negedge rx_clk);
      rx_reset = 1'b0;
      foreach (lines[i])
      begin
         line = lines[i];
         tag  = "";
         void'($sscanf(line, "%s", tag));
         case (tag)
            "T":
            begin
               close_test();
               void'($sscanf(line, "%s %s", tag, name));
               test_name = name;
               got_q.delete();
               exp_q.delete();
            end
            "F":
            begin
               void'($sscanf(line, "%s %d %h %h %d", tag, n, d, k, u));
               send_frame(n, d, k, u[0]);
            end
            "B":
            begin
               void'($sscanf(line, "%s %d %h %h %d %d", tag, v, d, k, l, u));
               drive_beat(v[0], d, k, l[0], u[0]);
            end
            "I":
               drive_beat(1'b0, '0, '0, 1'b0, 1'b0);
            "H":
            begin
               void'($sscanf(line, "%s %d", tag, v));
               out_hold = v[0];
            end
            "R":
               pulse_reset();
            "X":
            begin
               void'($sscanf(line, "%s %d %h %h", tag, n, d, k));
               for (int j = 0; j < n; j++)
                  exp_q.push_back(frame_beat(n, j, d, k));
            end
            "C":
               void'($sscanf(line, "%s %d %d", tag, exp_full, exp_bad));
            default:
               ;
         endcase
      end
      close_test();
      $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && pass_cnt > 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- test/ifm_stim.txt
# T name | F beats data0 last_keep user | B valid data keep last user | I idle | H hold
# R reset | X beats data0 last_keep (expected frame) | C drop_full drop_bad (totals)
T good_frames
F 1 a100000000000000 0f 1
I
F 2 a200000000000000 ff 1
I
F 8 a300000000000000 03 1
X 1 a100000000000000 0f
X 2 a200000000000000 ff
X 8 a300000000000000 03
C 0 0
T bad_frame
F 2 b100000000000000 7f 1
F 3 b200000000000000 ff 0
F 1 b300000000000000 01 1
X 2 b100000000000000 7f
X 1 b300000000000000 01
C 0 1
T back_to_back
F 3 c100000000000000 3f 1
F 1 c200000000000000 ff 1
F 4 c300000000000000 1f 1
X 3 c100000000000000 3f
X 1 c200000000000000 ff
X 4 c300000000000000 1f
C 0 1
T hold_overflow
H 1
F 8 d100000000000000 ff 1
F 8 d200000000000000 0f 1
F 6 d300000000000000 ff 1
I
I
F 3 d400000000000000 ff 1
F 1 d500000000000000 ff 1
H 0
X 8 d100000000000000 ff
X 8 d200000000000000 0f
X 6 d300000000000000 ff
C 2 1
T reset_mid_stream
H 1
F 3 e100000000000000 ff 1
B 1 e200000000000000 ff 0 1
B 1 e200000000000001 ff 0 1
R
H 0
F 2 e300000000000000 3f 1
X 2 e300000000000000 3f
C 0 0

//--- all.f
common/ifm_pkg.sv
verilog/ifm_fifo.sv
ifm_in/ifm_in_fsm.sv
ifm_out/ifm_out_fsm.sv
verilog/ifm_top.sv
test/ifm_tb.sv

//--- Bender.yml
package:
  name: ifm

sources:
  - common/ifm_pkg.sv
  - verilog/ifm_fifo.sv
  - ifm_in/ifm_in_fsm.sv
  - ifm_out/ifm_out_fsm.sv
  - verilog/ifm_top.sv
  - target: test
    files:
      - test/ifm_tb.sv
